// ==== mips16_ex.f ====
+incdir+design
+incdir+test
design/mips16_isa_pkg.sv
design/mips16_pipe_pkg.sv
design/pipe_ifs.sv
design/instr_decoder.sv
design/reg_file.sv
design/id_exe_stage.sv
design/exec_unit.sv
design/mips16_ex_top.sv
test/tb_mips16_ex.sv

// ==== Makefile ====
TOP = tb_mips16_ex
SRCS = $(wildcard design/*.sv design/*.svh test/*.sv test/*.svh)

all: run

obj_dir/V$(TOP): mips16_ex.f $(SRCS)
	verilator --binary --timing --assert --top-module $(TOP) -f mips16_ex.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

.PHONY: all run clean

// ==== test/tb_mips16_vectors.svh ====
//////////////////////////////////////////////////////////////////////
// Loads and register-immediate adds
add_row("li r1", 16'h6905, 16'h0, 0, 0, 1, 4'h1, 16'h0005, 0, 0, 16'h0, 16'h0);
add_row("li r2", 16'h6AF0, 16'h0, 0, 0, 1, 4'h2, 16'h00F0, 0, 0, 16'h0, 16'h0); // Zero-extended
add_row("move r3", 16'h7B20, 16'h0, 0, 0, 1, 4'h3, 16'h0005, 0, 0, 16'h0, 16'h0);
add_row("addiu r1", 16'h49FD, 16'h0, 0, 0, 1, 4'h1, 16'h0002, 0, 0, 16'h0, 16'h0); // 5 - 3
add_row("addiu3 r4", 16'h428E, 16'h0, 0, 0, 1, 4'h4, 16'h00EE, 0, 0, 16'h0, 16'h0);
//////////////////////////////////////////////////////////////////////
// ALU chain where each row reads the one before it
add_row("addu r5", 16'hE195, 16'h0, 0, 0, 1, 4'h5, 16'h00F0, 0, 0, 16'h0, 16'h0);
add_row("subu r6", 16'hE57B, 16'h0, 0, 0, 1, 4'h6, 16'h00EB, 0, 0, 16'h0, 16'h0);
add_row("and r6", 16'hEE4C, 16'h0, 0, 0, 1, 4'h6, 16'h00E0, 0, 0, 16'h0, 16'h0);
add_row("or r6", 16'hEE2D, 16'h0, 0, 0, 1, 4'h6, 16'h00E2, 0, 0, 16'h0, 16'h0);
add_row("cmp equal", 16'hED4A, 16'h0, 0, 0, 1, 4'hA, 16'h0000, 0, 0, 16'h0, 16'h0);
add_row("cmp differ", 16'hEE4A, 16'h0, 0, 0, 1, 4'hA, 16'h0001, 0, 0, 16'h0, 16'h0);
add_row("sll by 8", 16'h37C0, 16'h0, 0, 0, 1, 4'h7, 16'hE200, 0, 0, 16'h0, 16'h0); // Amount 0
add_row("sra r7", 16'h37F3, 16'h0, 0, 0, 1, 4'h7, 16'hFE20, 0, 0, 16'h0, 16'h0);
add_row("srl r3", 16'h33EE, 16'h0, 0, 0, 1, 4'h3, 16'h1FC4, 0, 0, 16'h0, 16'h0);
add_row("srav r7", 16'hE9E7, 16'h0, 0, 0, 1, 4'h7, 16'hFF88, 0, 0, 16'h0, 16'h0);
//////////////////////////////////////////////////////////////////////
// Special registers and pc
add_row("mtsp", 16'h64C0, 16'h0, 0, 0, 1, 4'h8, 16'h00E2, 0, 0, 16'h0, 16'h0);
add_row("addsp", 16'h63FE, 16'h0, 0, 0, 1, 4'h8, 16'h00E0, 0, 0, 16'h0, 16'h0);
add_row("mtih", 16'hF501, 16'h0, 0, 0, 1, 4'h9, 16'h00F0, 0, 0, 16'h0, 16'h0);
add_row("mfih", 16'hF400, 16'h0, 0, 0, 1, 4'h4, 16'h00F0, 0, 0, 16'h0, 16'h0);
add_row("mfpc", 16'hEB40, 16'h1234, 0, 0, 1, 4'h3, 16'h1235, 0, 0, 16'h0, 16'h0);
//////////////////////////////////////////////////////////////////////
// Memory requests
add_row("lw", 16'h991F, 16'h0, 0, 0, 0, 4'h0, 16'h0, 1, 0, 16'h0001, 16'h0); // r1 - 1
add_row("lw_sp", 16'h9004, 16'h0, 0, 0, 0, 4'h0, 16'h0, 1, 0, 16'h00E4, 16'h0);
add_row("sw", 16'hDD63, 16'h0, 0, 0, 0, 4'h0, 16'h0, 0, 1, 16'h00F3, 16'h1235);
add_row("sw_sp", 16'hD0F0, 16'h0, 0, 0, 0, 4'h0, 16'h0, 0, 1, 16'h00D0, 16'h00E0);
//////////////////////////////////////////////////////////////////////
// Hold, flush and words that do nothing
add_row("held sw", 16'hDD63, 16'h0, 1, 0, 0, 4'h0, 16'h0, 0, 0, 16'h0, 16'h0);
add_row("held li", 16'h6977, 16'h0, 1, 0, 0, 4'h0, 16'h0, 0, 0, 16'h0, 16'h0);
add_row("flushed lw_sp", 16'h9004, 16'h0, 0, 1, 0, 4'h0, 16'h0, 0, 0, 16'h0, 16'h0);
add_row("hold and flush", 16'h4905, 16'h0, 1, 1, 0, 4'h0, 16'h0, 0, 0, 16'h0, 16'h0);
add_row("branch word", 16'h1000, 16'h0, 0, 0, 0, 4'h0, 16'h0, 0, 0, 16'h0, 16'h0);
add_row("bad move", 16'h7B21, 16'h0, 0, 0, 0, 4'h0, 16'h0, 0, 0, 16'h0, 16'h0);
add_row("nop", 16'h0800, 16'h0, 0, 0, 0, 4'h0, 16'h0, 0, 0, 16'h0, 16'h0);
add_row("move r6", 16'h7E20, 16'h0, 0, 0, 1, 4'h6, 16'h0002, 0, 0, 16'h0, 16'h0); // r1 untouched

// ==== test/tb_mips16_ex.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips16_params.svh"

module tb_mips16_ex;

	localparam int CLK_PERIOD = 8;
	localparam int RANDOM_ROWS = 8;

	typedef struct packed {
		logic [`MIPS16_WORD-1:0] instr;
		logic [`MIPS16_WORD-1:0] pc;
		logic hold;
		logic flush;
		logic we;
		logic [`MIPS16_RADDR-1:0] wa;
		logic [`MIPS16_WORD-1:0] wd;
		logic mr;
		logic mw;
		logic [`MIPS16_WORD-1:0] ma;
		logic [`MIPS16_WORD-1:0] md;
	} row_t;

	logic clk = 1'b0;
	logic reset;
	logic instr_valid;
	logic [`MIPS16_WORD-1:0] instr;
	logic [`MIPS16_WORD-1:0] pc;
	logic hold;
	logic flush;
	logic wb_en;
	logic [`MIPS16_RADDR-1:0] wb_addr;
	logic [`MIPS16_WORD-1:0] wb_data;
	logic mem_read;
	logic mem_write;
	logic [`MIPS16_WORD-1:0] mem_addr;
	logic [`MIPS16_WORD-1:0] mem_wdata;
	logic [`MIPS16_WORD-1:0] mem_count;

	row_t rows[$];
	string names[$];
	logic table_ready = 1'b0;
	logic [31:0] lfsr_state = 32'h8359dad7;

	mips16_ex_top dut0 (.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.pc(pc), .hold(hold), .flush(flush), .wb_en(wb_en), .wb_addr(wb_addr),
		.wb_data(wb_data), .mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_count(mem_count));

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Table building and random bits
	task automatic add_row(input string name, input logic [15:0] instr_w,
		input logic [15:0] pc_w, input logic hold_w, input logic flush_w, input logic we,
		input logic [3:0] wa, input logic [15:0] wd, input logic mr, input logic mw,
		input logic [15:0] ma, input logic [15:0] md);
		row_t r;
		r = '{instr_w, pc_w, hold_w, flush_w, we, wa, wd, mr, mw, ma, md};
		rows.push_back(r);
		names.push_back(name);
	endtask

	// Each row holds name, instr, pc, hold, flush, wb en/addr/data and mem rd/wr/addr/wdata
	task automatic load_table();
		`include "tb_mips16_vectors.svh"
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	task automatic take_bits(input int count, output logic [7:0] value);
		value = '0;
		for (int b = 0; b < count; b++) begin
			value = {value[6:0], lfsr_state[0]}; // One step per bit
			lfsr_state = lfsr_step(lfsr_state);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Driving and checking
	task automatic check_value(input string name, input logic [15:0] expected,
		input logic [15:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
			$display("Test failures found");
			$fatal(1, "Output mismatch in %s", name);
		end
	endtask

	task automatic drive_row(input row_t r);
		instr_valid <= 1'b1;
		instr <= r.instr;
		pc <= r.pc;
		hold <= r.hold;
		flush <= r.flush;
	endtask

	task automatic check_row(input string name, input row_t r);
		check_value({name, " wb_en"}, 16'(r.we), 16'(wb_en));
		if (r.we) begin
			check_value({name, " wb_addr"}, 16'(r.wa), 16'(wb_addr));
			check_value({name, " wb_data"}, r.wd, wb_data);
		end
		check_value({name, " mem_read"}, 16'(r.mr), 16'(mem_read));
		check_value({name, " mem_write"}, 16'(r.mw), 16'(mem_write));
		if (r.mr || r.mw)
			check_value({name, " mem_addr"}, r.ma, mem_addr);
		if (r.mw)
			check_value({name, " mem_wdata"}, r.md, mem_wdata);
	endtask

	initial begin
		logic [7:0] reg_bits;
		logic [7:0] byte_bits;
		logic [15:0] exp_count;
		reset = 1'b1;
		instr_valid = 1'b0;
		instr = 16'h0800;
		pc = '0;
		hold = 1'b0;
		flush = 1'b0;
		exp_count = '0;
		load_table();
		for (int k = 0; k < RANDOM_ROWS; k++) begin
			take_bits(3, reg_bits);
			take_bits(8, byte_bits);
			// LI zero-extends its byte into rx
			add_row($sformatf("li random %0d", k), {5'b01101, reg_bits[2:0], byte_bits}, 16'h0,
				0, 0, 1, {1'b0, reg_bits[2:0]}, {8'h00, byte_bits}, 0, 0, 16'h0, 16'h0);
		end
		table_ready = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("reset wb_en", 16'h0, 16'(wb_en));
		check_value("reset mem_read", 16'h0, 16'(mem_read));
		check_value("reset mem_write", 16'h0, 16'(mem_write));
		check_value("reset mem_count", 16'h0, mem_count);
		for (int i = 0; i < rows.size() + 2; i++) begin
			@(posedge clk);
			if (i < rows.size()) begin
				drive_row(rows[i]);
			end else begin
				instr_valid <= 1'b0; // Drain the pipe
				instr <= 16'h0800;
			end
			@(negedge clk);
			if (i >= 1 && i <= rows.size()) begin
				if (rows[i-1].mr || rows[i-1].mw)
					exp_count = exp_count + 16'd1;
				check_value({names[i-1], " mem_count"}, exp_count, mem_count);
			end
			if (i >= 2)
				check_row(names[i-2], rows[i-2]); // Two cycles after issue
		end
		$display("All tests passed!");
		$finish;
	end

	// Watchdog sized from the table length
	initial begin
		wait (table_ready);
		#((rows.size() + 10) * CLK_PERIOD);
		$display("Test failures found");
		$fatal(1, "Timeout, the table did not finish in the expected number of cycles");
	end

endmodule

`default_nettype wire

// ==== design/mips16_ex_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips16_params.svh"

module mips16_ex_top (
	input logic clk,
	input logic reset,
	input logic instr_valid,
	input logic [`MIPS16_WORD-1:0] instr,
	input logic [`MIPS16_WORD-1:0] pc,
	input logic hold,
	input logic flush,
	output logic wb_en,
	output logic [`MIPS16_RADDR-1:0] wb_addr,
	output logic [`MIPS16_WORD-1:0] wb_data,
	output logic mem_read,
	output logic mem_write,
	output logic [`MIPS16_WORD-1:0] mem_addr,
	output logic [`MIPS16_WORD-1:0] mem_wdata,
	output logic [`MIPS16_WORD-1:0] mem_count
);

	mips16_pipe_pkg::reg_addr_t rs_a;
	mips16_pipe_pkg::reg_addr_t rs_b;
	logic [`MIPS16_WORD-1:0] rdata_a;
	logic [`MIPS16_WORD-1:0] rdata_b;
	logic rf_wb_en; // Execute-cycle write port
	mips16_pipe_pkg::reg_addr_t rf_wb_addr;
	logic [`MIPS16_WORD-1:0] rf_wb_data;

	dec_if dec_bus ();
	id_ex_if ex_bus ();

	instr_decoder dec0 (.instr(instr), .instr_valid(instr_valid), .rs_a(rs_a), .rs_b(rs_b),
		.dec(dec_bus));

	reg_file rf0 (.clk(clk), .reset(reset), .rs_a(rs_a), .rs_b(rs_b), .rdata_a(rdata_a),
		.rdata_b(rdata_b), .wb_en(rf_wb_en), .wb_addr(rf_wb_addr), .wb_data(rf_wb_data));

	id_exe_stage idex0 (.clk(clk), .reset(reset), .hold(hold), .flush(flush), .pc(pc),
		.rdata_a(rdata_a), .rdata_b(rdata_b), .dec(dec_bus), .ex(ex_bus), .mem_count(mem_count));

	// Registered copies leave the top two cycles after issue
	exec_unit exu0 (.clk(clk), .reset(reset), .ex(ex_bus), .wb_en(rf_wb_en), .wb_addr(rf_wb_addr),
		.wb_data(rf_wb_data), .mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .res_en(wb_en), .res_addr(wb_addr), .res_data(wb_data));

endmodule

`default_nettype wire

// ==== design/exec_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips16_params.svh"

module exec_unit (
	input logic clk,
	input logic reset,
	id_ex_if.recv ex,
	output logic wb_en,
	output mips16_pipe_pkg::reg_addr_t wb_addr,
	output logic [`MIPS16_WORD-1:0] wb_data,
	output logic mem_read,
	output logic mem_write,
	output logic [`MIPS16_WORD-1:0] mem_addr,
	output logic [`MIPS16_WORD-1:0] mem_wdata,
	output logic res_en,
	output mips16_pipe_pkg::reg_addr_t res_addr,
	output logic [`MIPS16_WORD-1:0] res_data
);

	logic [`MIPS16_WORD-1:0] sum;
	logic [`MIPS16_WORD-1:0] result;

	assign sum = ex.op1 + ex.op2; // Also the memory address

	always_comb begin
		case (ex.op)
			mips16_pipe_pkg::EX_ADD: result = sum;
			mips16_pipe_pkg::EX_SUB: result = ex.op1 - ex.op2;
			mips16_pipe_pkg::EX_AND: result = ex.op1 & ex.op2;
			mips16_pipe_pkg::EX_OR: result = ex.op1 | ex.op2;
			mips16_pipe_pkg::EX_CMP: result = (ex.op1 == ex.op2) ? '0 : `MIPS16_WORD'(1);
			mips16_pipe_pkg::EX_SLL: result = ex.op1 << ex.op2[3:0];
			mips16_pipe_pkg::EX_SRL: result = ex.op1 >> ex.op2[3:0];
			mips16_pipe_pkg::EX_SRA: result = $signed(ex.op1) >>> ex.op2[3:0];
			mips16_pipe_pkg::EX_PASS: result = ex.op1;
			default: result = '0;
		endcase
	end

	// Register file write in the execute cycle
	assign wb_en = ex.valid && ex.reg_write;
	assign wb_addr = ex.rd_addr;
	assign wb_data = result;

	always_ff @(posedge clk) begin
		if (reset) begin
			res_en <= 1'b0;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
		end else begin
			res_en <= wb_en;
			mem_read <= ex.valid && ex.mem_read;
			mem_write <= ex.valid && ex.mem_write;
		end
	end

	always_ff @(posedge clk) begin
		res_addr <= wb_addr;
		res_data <= result;
		mem_addr <= sum;
		mem_wdata <= ex.store_data;
	end

	// Stores never write a register
	a_store_no_wb: assert property (@(posedge clk) disable iff (reset)
		!(res_en && mem_write));

endmodule

`default_nettype wire

// ==== design/id_exe_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips16_params.svh"

module id_exe_stage (
	input logic clk,
	input logic reset,
	input logic hold,
	input logic flush,
	input logic [`MIPS16_WORD-1:0] pc,
	input logic [`MIPS16_WORD-1:0] rdata_a,
	input logic [`MIPS16_WORD-1:0] rdata_b,
	dec_if.recv dec,
	id_ex_if.drive ex,
	output logic [`MIPS16_WORD-1:0] mem_count
);

	logic [`MIPS16_WORD-1:0] imm_ext;
	logic [`MIPS16_WORD-1:0] op1_next;
	logic [`MIPS16_WORD-1:0] op2_next;
	logic take;

	assign take = !flush && !hold;

	//////////////////////////////////////////////////////////////////////
	// Operand forming
	always_comb begin
		case (dec.imm_kind)
			mips16_isa_pkg::IMM_SE8: imm_ext = {{8{dec.imm_field[7]}}, dec.imm_field[7:0]};
			mips16_isa_pkg::IMM_SE4: imm_ext = {{12{dec.imm_field[3]}}, dec.imm_field[3:0]};
			mips16_isa_pkg::IMM_SE5: imm_ext = {{11{dec.imm_field[4]}}, dec.imm_field[4:0]};
			mips16_isa_pkg::IMM_SH3: begin
				// Zero amount encodes a shift by 8
				imm_ext = (dec.imm_field[4:2] == 3'b000) ? `MIPS16_WORD'(8) :
					{13'b0, dec.imm_field[4:2]};
			end
			default: imm_ext = '0;
		endcase
	end

	always_comb begin
		if (dec.imm_kind == mips16_isa_pkg::IMM_ZE8)
			op1_next = {8'b0, dec.imm_field[7:0]}; // LI byte
		else if (dec.imm_kind == mips16_isa_pkg::IMM_PC1)
			op1_next = pc + `MIPS16_WORD'(1); // MFPC
		else if (dec.a_from_b)
			op1_next = rdata_b;
		else
			op1_next = rdata_a;
	end

	// Ports swap when op1 is taken from B, so SRAV gets its amount from A
	assign op2_next = !dec.use_b ? imm_ext : dec.a_from_b ? rdata_a : rdata_b;

	//////////////////////////////////////////////////////////////////////
	// Stage register
	always_ff @(posedge clk) begin
		if (reset) begin
			ex.valid <= 1'b0;
			ex.reg_write <= 1'b0;
			ex.mem_read <= 1'b0;
			ex.mem_write <= 1'b0;
			mem_count <= '0;
		end else if (!take) begin
			ex.valid <= 1'b0; // Offered word dropped, held entry not rerun
		end else begin
			ex.valid <= dec.valid;
			ex.reg_write <= dec.reg_write;
			ex.mem_read <= dec.mem_read;
			ex.mem_write <= dec.mem_write;
			if (dec.valid && (dec.mem_read || dec.mem_write))
				mem_count <= mem_count + `MIPS16_WORD'(1);
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			ex.op <= dec.op;
			ex.op1 <= op1_next;
			ex.op2 <= op2_next;
			ex.store_data <= rdata_b;
			ex.rd_addr <= dec.rd_addr;
		end
	end

	a_mem_excl: assert property (@(posedge clk) disable iff (reset)
		!(ex.mem_read && ex.mem_write));

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips16_params.svh"

module reg_file (
	input logic clk,
	input logic reset,
	input mips16_pipe_pkg::reg_addr_t rs_a,
	input mips16_pipe_pkg::reg_addr_t rs_b,
	output logic [`MIPS16_WORD-1:0] rdata_a,
	output logic [`MIPS16_WORD-1:0] rdata_b,
	input logic wb_en,
	input mips16_pipe_pkg::reg_addr_t wb_addr,
	input logic [`MIPS16_WORD-1:0] wb_data
);

	logic [`MIPS16_WORD-1:0] regs [`REG_COUNT]; // r0-r7, SP, IH, T

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (wb_en) begin
			regs[wb_addr] <= wb_data;
		end
	end

	// Write-through so a consumer can follow its producer directly
	assign rdata_a = (wb_en && wb_addr == rs_a) ? wb_data :
		(rs_a < `REG_COUNT) ? regs[rs_a] : '0;
	assign rdata_b = (wb_en && wb_addr == rs_b) ? wb_data :
		(rs_b < `REG_COUNT) ? regs[rs_b] : '0;

	a_wb_addr_range: assert property (@(posedge clk) disable iff (reset)
		wb_en |-> wb_addr < `REG_COUNT);

endmodule

`default_nettype wire

// ==== design/instr_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips16_params.svh"

module instr_decoder (
	input logic [`MIPS16_WORD-1:0] instr,
	input logic instr_valid,
	output mips16_pipe_pkg::reg_addr_t rs_a,
	output mips16_pipe_pkg::reg_addr_t rs_b,
	dec_if.drive dec
);

	localparam mips16_pipe_pkg::reg_addr_t SP_ADDR = mips16_pipe_pkg::reg_addr_t'(`REG_SP);
	localparam mips16_pipe_pkg::reg_addr_t IH_ADDR = mips16_pipe_pkg::reg_addr_t'(`REG_IH);
	localparam mips16_pipe_pkg::reg_addr_t T_ADDR = mips16_pipe_pkg::reg_addr_t'(`REG_T);

	mips16_isa_pkg::major_op_e major;
	mips16_pipe_pkg::reg_addr_t rx;
	mips16_pipe_pkg::reg_addr_t ry;
	mips16_pipe_pkg::reg_addr_t rz;
	logic low5_zero;

	assign major = mips16_isa_pkg::major_op_e'(instr[15:11]);
	assign rx = {1'b0, instr[10:8]};
	assign ry = {1'b0, instr[7:5]};
	assign rz = {1'b0, instr[4:2]};
	assign low5_zero = (instr[4:0] == 5'b00000);

	assign dec.valid = instr_valid;
	assign dec.imm_field = instr[10:0];
	// Every kept op that touches no memory writes a register
	assign dec.reg_write = (dec.op != mips16_pipe_pkg::EX_NONE) && !dec.mem_read && !dec.mem_write;

	always_comb begin
		rs_a = '0;
		rs_b = '0;
		dec.rd_addr = rx;
		dec.mem_read = 1'b0;
		dec.mem_write = 1'b0;
		dec.op = mips16_pipe_pkg::EX_NONE;
		dec.imm_kind = mips16_isa_pkg::IMM_NONE;
		dec.use_b = 1'b0;
		dec.a_from_b = 1'b0;
		case (major)
			mips16_isa_pkg::MAJ_ADDIU: begin
				rs_a = rx;
				dec.op = mips16_pipe_pkg::EX_ADD;
				dec.imm_kind = mips16_isa_pkg::IMM_SE8;
			end
			mips16_isa_pkg::MAJ_ADDIU3: begin
				rs_a = rx;
				dec.rd_addr = ry;
				dec.op = mips16_pipe_pkg::EX_ADD;
				dec.imm_kind = mips16_isa_pkg::IMM_SE4;
			end
			mips16_isa_pkg::MAJ_SP: begin
				dec.rd_addr = SP_ADDR;
				if (instr[10:8] == mips16_isa_pkg::SP_ADDSP) begin
					rs_a = SP_ADDR;
					dec.op = mips16_pipe_pkg::EX_ADD;
					dec.imm_kind = mips16_isa_pkg::IMM_SE8;
				end else if (instr[10:8] == mips16_isa_pkg::SP_MTSP && low5_zero) begin
					rs_a = ry; // MTSP source sits in [7:5]
					dec.op = mips16_pipe_pkg::EX_PASS;
				end
			end
			mips16_isa_pkg::MAJ_RRR: begin
				rs_a = rx;
				rs_b = ry;
				dec.rd_addr = rz;
				dec.use_b = 1'b1;
				if (instr[1:0] == mips16_isa_pkg::RRR_ADDU)
					dec.op = mips16_pipe_pkg::EX_ADD;
				else if (instr[1:0] == mips16_isa_pkg::RRR_SUBU)
					dec.op = mips16_pipe_pkg::EX_SUB;
			end
			mips16_isa_pkg::MAJ_RR: begin
				rs_a = rx;
				rs_b = ry;
				dec.use_b = 1'b1;
				if (instr[7:0] == mips16_isa_pkg::MFPC_LOW) begin
					dec.op = mips16_pipe_pkg::EX_PASS;
					dec.imm_kind = mips16_isa_pkg::IMM_PC1;
				end else begin
					case (instr[4:0])
						mips16_isa_pkg::RR_AND: dec.op = mips16_pipe_pkg::EX_AND;
						mips16_isa_pkg::RR_OR: dec.op = mips16_pipe_pkg::EX_OR;
						mips16_isa_pkg::RR_CMP: begin
							dec.op = mips16_pipe_pkg::EX_CMP;
							dec.rd_addr = T_ADDR;
						end
						mips16_isa_pkg::RR_SRAV: begin
							dec.op = mips16_pipe_pkg::EX_SRA;
							dec.rd_addr = ry; // ry >>= rx
							dec.a_from_b = 1'b1;
						end
						default: ;
					endcase
				end
			end
			mips16_isa_pkg::MAJ_LI: begin
				dec.op = mips16_pipe_pkg::EX_PASS;
				dec.imm_kind = mips16_isa_pkg::IMM_ZE8;
			end
			mips16_isa_pkg::MAJ_MOVE: begin
				rs_b = ry;
				dec.a_from_b = 1'b1;
				if (low5_zero)
					dec.op = mips16_pipe_pkg::EX_PASS;
			end
			mips16_isa_pkg::MAJ_IH: begin
				if (instr[7:0] == mips16_isa_pkg::IH_MFIH) begin
					rs_a = IH_ADDR;
					dec.op = mips16_pipe_pkg::EX_PASS;
				end else if (instr[7:0] == mips16_isa_pkg::IH_MTIH) begin
					rs_a = rx;
					dec.rd_addr = IH_ADDR;
					dec.op = mips16_pipe_pkg::EX_PASS;
				end
			end
			mips16_isa_pkg::MAJ_SHIFT: begin
				rs_b = ry;
				dec.a_from_b = 1'b1;
				dec.imm_kind = mips16_isa_pkg::IMM_SH3;
				case (instr[1:0])
					mips16_isa_pkg::SH_SLL: dec.op = mips16_pipe_pkg::EX_SLL;
					mips16_isa_pkg::SH_SRL: dec.op = mips16_pipe_pkg::EX_SRL;
					mips16_isa_pkg::SH_SRA: dec.op = mips16_pipe_pkg::EX_SRA;
					default: ;
				endcase
			end
			//////////////////////////////////////////////////////////////////////
			// Memory group with the address always op1 + immediate
			mips16_isa_pkg::MAJ_LW, mips16_isa_pkg::MAJ_SW: begin
				rs_a = rx;
				rs_b = ry; // Store data for SW
				dec.op = mips16_pipe_pkg::EX_ADD;
				dec.imm_kind = mips16_isa_pkg::IMM_SE5;
				dec.mem_read = (major == mips16_isa_pkg::MAJ_LW);
				dec.mem_write = (major == mips16_isa_pkg::MAJ_SW);
			end
			mips16_isa_pkg::MAJ_LW_SP, mips16_isa_pkg::MAJ_SW_SP: begin
				rs_a = SP_ADDR;
				rs_b = SP_ADDR; // SW_SP stores SP
				dec.op = mips16_pipe_pkg::EX_ADD;
				dec.imm_kind = mips16_isa_pkg::IMM_SE8;
				dec.mem_read = (major == mips16_isa_pkg::MAJ_LW_SP);
				dec.mem_write = (major == mips16_isa_pkg::MAJ_SW_SP);
			end
			mips16_isa_pkg::MAJ_NOP: ; // Also the fate of any unknown word
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== design/pipe_ifs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mips16_params.svh"

// Decoder to id/exe register
interface dec_if;
	logic valid;
	mips16_pipe_pkg::reg_addr_t rd_addr;
	logic reg_write;
	logic mem_read;
	logic mem_write;
	mips16_pipe_pkg::exe_op_e op;
	mips16_isa_pkg::imm_kind_e imm_kind;
	logic use_b; // op2 from port B
	logic a_from_b; // op1 from port B
	logic [10:0] imm_field;

	modport drive (output valid, rd_addr, reg_write, mem_read, mem_write, op, imm_kind,
		use_b, a_from_b, imm_field);
	modport recv (input valid, rd_addr, reg_write, mem_read, mem_write, op, imm_kind,
		use_b, a_from_b, imm_field);
endinterface

// Id/exe register to execute
interface id_ex_if;
	logic valid;
	mips16_pipe_pkg::exe_op_e op;
	logic [`MIPS16_WORD-1:0] op1;
	logic [`MIPS16_WORD-1:0] op2;
	logic [`MIPS16_WORD-1:0] store_data;
	mips16_pipe_pkg::reg_addr_t rd_addr;
	logic reg_write;
	logic mem_read;
	logic mem_write;

	modport drive (output valid, op, op1, op2, store_data, rd_addr, reg_write, mem_read, mem_write);
	modport recv (input valid, op, op1, op2, store_data, rd_addr, reg_write, mem_read, mem_write);
endinterface

`default_nettype wire

// ==== design/mips16_pipe_pkg.sv ====
`default_nettype none

`include "mips16_params.svh"

package mips16_pipe_pkg;

	typedef logic [`MIPS16_RADDR-1:0] reg_addr_t;

	// Operation carried into execute
	typedef enum logic [3:0] {
		EX_ADD,
		EX_SUB,
		EX_AND,
		EX_OR,
		EX_CMP,
		EX_SLL,
		EX_SRL,
		EX_SRA,
		EX_PASS,
		EX_NONE
	} exe_op_e;

endpackage

`default_nettype wire

// ==== design/mips16_isa_pkg.sv ====
`default_nettype none

package mips16_isa_pkg;

	typedef enum logic [4:0] {
		MAJ_NOP    = 5'b00001,
		MAJ_SHIFT  = 5'b00110,
		MAJ_ADDIU3 = 5'b01000,
		MAJ_ADDIU  = 5'b01001,
		MAJ_SP     = 5'b01100, // ADDSP, MTSP
		MAJ_LI     = 5'b01101,
		MAJ_MOVE   = 5'b01111,
		MAJ_LW_SP  = 5'b10010,
		MAJ_LW     = 5'b10011,
		MAJ_SW_SP  = 5'b11010,
		MAJ_SW     = 5'b11011,
		MAJ_RRR    = 5'b11100, // ADDU, SUBU
		MAJ_RR     = 5'b11101, // AND, OR, CMP, SRAV, MFPC
		MAJ_IH     = 5'b11110  // MFIH, MTIH
	} major_op_e;

	typedef enum logic [2:0] {SP_ADDSP = 3'b011, SP_MTSP = 3'b100} sp_sub_e; // instr[10:8]
	typedef enum logic [1:0] {RRR_ADDU = 2'b01, RRR_SUBU = 2'b11} rrr_func_e; // instr[1:0]
	typedef enum logic [1:0] {SH_SLL = 2'b00, SH_SRL = 2'b10, SH_SRA = 2'b11} shift_func_e;
	typedef enum logic [7:0] {IH_MFIH = 8'h00, IH_MTIH = 8'h01} ih_func_e; // instr[7:0]

	typedef enum logic [4:0] {
		RR_SRAV = 5'b00111,
		RR_CMP  = 5'b01010,
		RR_AND  = 5'b01100,
		RR_OR   = 5'b01101
	} rr_func_e;

	localparam logic [7:0] MFPC_LOW = 8'b0100_0000; // Low byte of MFPC in the RR group

	typedef enum logic [2:0] {
		IMM_NONE,
		IMM_SE8,
		IMM_SE4,
		IMM_SE5,
		IMM_ZE8,
		IMM_SH3, // 0 means 8
		IMM_PC1
	} imm_kind_e;

endpackage

`default_nettype wire

// ==== design/mips16_params.svh ====
`ifndef MIPS16_PARAMS_SVH
`define MIPS16_PARAMS_SVH

// Datapath and register file sizes
`define MIPS16_WORD 16
`define MIPS16_RADDR 4
`define REG_COUNT 11

// Special registers sit above the eight general ones
`define REG_SP 8
`define REG_IH 9
`define REG_T 10

`endif
